// File: rename_stage.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/resolver.sv
verilog/rename_stage.sv
dv/rename_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator.
# Run from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 \
  -f rename_stage.f \
  --top-module rename_stage_tb \
  -o rename_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rename_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "No pass line found in $LOG"
  exit 1
fi
exit 0

// File: dv/rename_trace.txt
# P/X: c0 w0 addr0 imm0 rs1_0 rs2_0 rd0 c1 w1 addr1 imm1 rs1_1 rs2_1 rd1
# then: ps1_0 ps2_0 pd0 oldpd0 tag0 ps1_1 ps2_1 pd1 oldpd1 tag1 (all hex); R preg; B; S cycles
P 1 1 1000 10 02 03 01 1 1 1004 11 05 06 04 02 03 20 01 0 05 06 21 04 0
P 1 1 1008 12 01 04 07 1 1 100c 13 07 02 08 20 21 22 07 0 22 02 23 08 0
P 2 1 1010 14 07 08 09 1 1 1014 15 09 00 09 22 23 24 09 0 24 00 25 24 0
P 1 1 1018 16 09 08 0a 2 0 101c 17 09 01 0b 25 23 26 0a 0 25 20 00 00 0
P 1 1 1020 18 01 02 00 1 1 1024 19 00 00 0c 20 02 00 00 0 00 00 27 0c 0
P 3 1 1028 1a 02 00 01 1 1 102c 1b 01 00 0d 02 00 28 20 0 28 00 29 0d 1
P 1 1 1030 1c 01 01 02 1 0 1034 1d 0d 00 00 28 28 2a 02 1 29 00 00 00 1
B
P 1 1 1038 1e 02 00 03 3 0 103c 1f 03 00 00 2a 00 2b 03 0 2b 00 00 00 0
B
P 1 1 1040 20 03 02 05 1 1 1044 21 05 00 06 2b 2a 2c 05 0 2c 00 2d 06 0
S 14
P 1 1 1048 22 05 06 0e 1 1 104c 23 0e 00 0f 2c 2d 2e 0e 0 2e 00 2f 0f 0
P 1 1 1050 24 0f 00 10 1 1 1054 25 10 00 11 2f 00 30 10 0 30 00 31 11 0
P 1 1 1058 26 00 00 14 1 1 105c 27 00 00 15 00 00 32 14 0 00 00 33 15 0
P 1 1 1060 28 00 00 14 1 1 1064 29 00 00 15 00 00 34 32 0 00 00 35 33 0
P 1 1 1068 2a 00 00 14 1 1 106c 2b 00 00 15 00 00 36 34 0 00 00 37 35 0
P 1 1 1070 2c 00 00 14 1 1 1074 2d 00 00 15 00 00 38 36 0 00 00 39 37 0
P 1 1 1078 2e 00 00 14 1 1 107c 2f 00 00 15 00 00 3a 38 0 00 00 3b 39 0
P 1 1 1080 30 00 00 14 1 1 1084 31 00 00 15 00 00 3c 3a 0 00 00 3d 3b 0
P 1 1 1088 32 00 00 14 1 1 108c 33 00 00 15 00 00 3e 3c 0 00 00 3f 3d 0
X 1 1 1090 34 00 00 16 1 1 1094 35 00 00 17 00 00 00 00 0 00 00 00 00 0
R 01
R 04
P 1 1 1090 34 00 00 16 1 1 1094 35 00 00 17 00 00 01 16 0 00 00 04 17 0

// File: dv/rename_stage_tb.sv
/*
  Testbench for the rename stage.
  Replays dv/rename_trace.txt: pairs with expected results, releases,
  branch resolves and dispatch stalls, and reports the error count.
*/
`timescale 1ns/1ns
`default_nettype none

module rename_stage_tb
  import rename_pkg::*;
();

  localparam int TIMEOUT = 200;  // Cycles per wait

  logic         global_bus;
  logic         rst_n;
  logic         in_req;
  instr_class_e class_0, class_1;
  logic         writes_0, writes_1;
  word_t        address_0, address_1, imm_0, imm_1;
  areg_t        rs_1_0, rs_2_0, rd_0, rs_1_1, rs_2_1, rd_1;
  logic         in_ack, stall;
  logic         dispatch_stall, branch_resolved;
  logic         release_valid;
  preg_t        release_preg;
  logic         out_valid;
  instr_class_e out_class_0, out_class_1;
  word_t        out_address_0, out_address_1, out_imm_0, out_imm_1;
  preg_t        out_ps_1_0, out_ps_2_0, out_ps_1_1, out_ps_2_1;
  areg_t        out_rd_0, out_rd_1;
  preg_t        out_pd_0, out_pd_1, out_old_pd_0, out_old_pd_1;
  logic         out_tag_0, out_tag_1;

  int          errors;
  int          checks;
  int          stall_left;
  logic [31:0] lcg_state;
  logic [31:0] tv [24];   // Trace record with payload then expected values
  logic        have_held;
  preg_t       held_pd_0, held_pd_1;

  rename_stage u_rename_stage (.*);

  initial begin
    global_bus = 1'b0;
    forever #2 global_bus = ~global_bus;
  end

  // Advance one cycle and change inputs 1 ns after the edge
  task automatic tick();
    @(posedge global_bus);
    #1;
    if (stall_left > 0) begin
      stall_left--;
      if (stall_left == 0) dispatch_stall = 1'b0;
    end
  endtask

  function automatic logic [1:0] next_gap();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[17:16];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("FAILED %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic apply_payload();
    class_0   = instr_class_e'(tv[0][1:0]);
    writes_0  = tv[1][0];
    address_0 = tv[2];
    imm_0     = tv[3];
    rs_1_0    = areg_t'(tv[4]);
    rs_2_0    = areg_t'(tv[5]);
    rd_0      = areg_t'(tv[6]);
    class_1   = instr_class_e'(tv[7][1:0]);
    writes_1  = tv[8][0];
    address_1 = tv[9];
    imm_1     = tv[10];
    rs_1_1    = areg_t'(tv[11]);
    rs_2_1    = areg_t'(tv[12]);
    rd_1      = areg_t'(tv[13]);
  endtask

  task automatic wait_ack_low();
    int n;
    n = 0;
    while (in_ack && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (in_ack) begin
      $display("Timeout waiting for in_ack to fall");
      errors++;
    end
  endtask

  task automatic check_outputs();
    check_val("out_valid", 32'd1, {31'd0, out_valid});
    check_val("out_class_0", tv[0], {30'd0, out_class_0});
    check_val("out_address_0", tv[2], out_address_0);
    check_val("out_imm_0", tv[3], out_imm_0);
    check_val("out_rd_0", tv[6], {27'd0, out_rd_0});
    check_val("out_ps_1_0", tv[14], {26'd0, out_ps_1_0});
    check_val("out_ps_2_0", tv[15], {26'd0, out_ps_2_0});
    check_val("out_pd_0", tv[16], {26'd0, out_pd_0});
    check_val("out_old_pd_0", tv[17], {26'd0, out_old_pd_0});
    check_val("out_tag_0", tv[18], {31'd0, out_tag_0});
    check_val("out_class_1", tv[7], {30'd0, out_class_1});
    check_val("out_address_1", tv[9], out_address_1);
    check_val("out_imm_1", tv[10], out_imm_1);
    check_val("out_rd_1", tv[13], {27'd0, out_rd_1});
    check_val("out_ps_1_1", tv[19], {26'd0, out_ps_1_1});
    check_val("out_ps_2_1", tv[20], {26'd0, out_ps_2_1});
    check_val("out_pd_1", tv[21], {26'd0, out_pd_1});
    check_val("out_old_pd_1", tv[22], {26'd0, out_old_pd_1});
    check_val("out_tag_1", tv[23], {31'd0, out_tag_1});
  endtask

  // Full four-phase transfer of one pair
  task automatic send_pair();
    int   n;
    logic blocked;
    wait_ack_low();
    apply_payload();
    in_req = 1'b1;
    n = 0;
    while (!in_ack && n < TIMEOUT) begin
      blocked = have_held && out_valid && dispatch_stall;  // Previous pair stuck in output
      tick();
      n++;
      if (blocked) begin
        check_val("in_ack", 32'd0, {31'd0, in_ack});
        check_val("out_valid", 32'd1, {31'd0, out_valid});
        check_val("held out_pd_0", {26'd0, held_pd_0}, {26'd0, out_pd_0});
        check_val("held out_pd_1", {26'd0, held_pd_1}, {26'd0, out_pd_1});
      end
    end
    if (!in_ack) begin
      $display("Timeout waiting for in_ack to rise");
      errors++;
    end else begin
      check_outputs();
    end
    held_pd_0 = preg_t'(tv[16]);
    held_pd_1 = preg_t'(tv[21]);
    have_held = 1'b1;
    in_req = 1'b0;
    wait_ack_low();
  endtask

  // Pair that must stall on an empty free list, then is withdrawn
  task automatic stalled_pair();
    wait_ack_low();
    apply_payload();
    in_req = 1'b1;
    repeat (3) begin
      tick();
      check_val("stall", 32'd1, {31'd0, stall});
      check_val("in_ack", 32'd0, {31'd0, in_ack});
    end
    in_req = 1'b0;
    tick();
  endtask

  initial begin
    int fd;
    int v;
    int cnt;
    logic [7:0] op;
    logic [8*200-1:0] line;
    errors          = 0;
    checks          = 0;
    stall_left      = 0;
    lcg_state       = 32'hd03c;
    have_held       = 1'b0;
    rst_n           = 1'b0;
    in_req          = 1'b0;
    class_0         = CLASS_NONE;
    class_1         = CLASS_NONE;
    writes_0        = 1'b0;
    writes_1        = 1'b0;
    address_0       = '0;
    address_1       = '0;
    imm_0           = '0;
    imm_1           = '0;
    rs_1_0          = '0;
    rs_2_0          = '0;
    rd_0            = '0;
    rs_1_1          = '0;
    rs_2_1          = '0;
    rd_1            = '0;
    dispatch_stall  = 1'b0;
    branch_resolved = 1'b0;
    release_valid   = 1'b0;
    release_preg    = '0;
    repeat (2) tick();
    rst_n = 1'b1;
    tick();

    fd = $fopen("dv/rename_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file dv/rename_trace.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %s", op) == 1) begin
        if (op == "#") begin
          cnt = $fgets(line, fd);  // Rest of a comment line
        end else if (op == "P" || op == "X") begin
          for (int i = 0; i < 24; i++) begin
            cnt = $fscanf(fd, " %h", v);
            tv[i] = v;
          end
          if (op == "P") send_pair();
          else stalled_pair();
        end else if (op == "R") begin
          cnt = $fscanf(fd, " %h", v);
          release_valid = 1'b1;
          release_preg  = preg_t'(v);
          tick();
          release_valid = 1'b0;
        end else if (op == "B") begin
          branch_resolved = 1'b1;
          tick();
          branch_resolved = 1'b0;
        end else if (op == "S") begin
          cnt = $fscanf(fd, " %d", v);
          dispatch_stall = 1'b1;
          stall_left     = v;
        end else begin
          $display("Unknown record type in trace file");
          errors++;
        end
        repeat (next_gap()) tick();
      end
      $fclose(fd);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/rename_stage.sv
/*
  Register-rename stage of the dual-issue core.
  Connects the resolver to the map table and the free list; the decoder
  drives the pair side, dispatch and retirement drive the rest.
*/
`timescale 1ns/1ns
`default_nettype none

module rename_stage
  import rename_pkg::*;
(
  input  logic         global_bus,
  input  logic         rst_n,
  // Pair from decode
  input  logic         in_req,
  input  instr_class_e class_0, class_1,
  input  logic         writes_0, writes_1,
  input  word_t        address_0, address_1,
  input  word_t        imm_0, imm_1,
  input  areg_t        rs_1_0, rs_2_0, rd_0,
  input  areg_t        rs_1_1, rs_2_1, rd_1,
  output logic         in_ack,
  output logic         stall,
  // Dispatch and retirement
  input  logic         dispatch_stall,
  input  logic         branch_resolved,
  input  logic         release_valid,
  input  preg_t        release_preg,
  output logic         out_valid,
  output instr_class_e out_class_0, out_class_1,
  output word_t        out_address_0, out_address_1,
  output word_t        out_imm_0, out_imm_1,
  output preg_t        out_ps_1_0, out_ps_2_0, out_ps_1_1, out_ps_2_1,
  output areg_t        out_rd_0, out_rd_1,
  output preg_t        out_pd_0, out_pd_1,
  output preg_t        out_old_pd_0, out_old_pd_1,
  output logic         out_tag_0, out_tag_1
);

  areg_t      map_rs_1_0, map_rs_2_0, map_rd_0;
  areg_t      map_rs_1_1, map_rs_2_1, map_rd_1;
  preg_t      map_ps_1_0, map_ps_2_0, map_old_pd_0;
  preg_t      map_ps_1_1, map_ps_2_1, map_old_pd_1;
  logic       map_we_0, map_we_1;
  preg_t      map_pd_0, map_pd_1;
  preg_t      head_0, head_1;
  logic [1:0] pop_count;

  // Port names line up with the stage, so the resolver connects by name
  resolver u_resolver (.*);

  rename_map u_rename_map (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rs_1_0     (map_rs_1_0),
    .rs_2_0     (map_rs_2_0),
    .rd_0       (map_rd_0),
    .rs_1_1     (map_rs_1_1),
    .rs_2_1     (map_rs_2_1),
    .rd_1       (map_rd_1),
    .map_we_0   (map_we_0),
    .map_we_1   (map_we_1),
    .pd_0       (map_pd_0),
    .pd_1       (map_pd_1),
    .ps_1_0     (map_ps_1_0),
    .ps_2_0     (map_ps_2_0),
    .ps_1_1     (map_ps_1_1),
    .ps_2_1     (map_ps_2_1),
    .old_pd_0   (map_old_pd_0),
    .old_pd_1   (map_old_pd_1)
  );

  free_list u_free_list (
    .global_bus    (global_bus),
    .rst_n         (rst_n),
    .pop_count     (pop_count),
    .release_valid (release_valid),
    .release_preg  (release_preg),
    .head_0        (head_0),
    .head_1        (head_1),
    .free_count    ()  // Occupancy is only visible inside the free list
  );

endmodule

`default_nettype wire

// File: verilog/resolver.sv
/*
  Rename resolver for a dual-issue pair.
  Takes the pair on a four-phase req/ack handshake, assigns new physical
  registers from the free list, bypasses slot 0's rd into slot 1's sources,
  tags speculative instructions and holds the result for dispatch.
*/
`timescale 1ns/1ns
`default_nettype none

module resolver
  import rename_pkg::*;
(
  input  logic         global_bus,
  input  logic         rst_n,
  // Pair input
  input  logic         in_req,
  input  instr_class_e class_0, class_1,
  input  logic         writes_0, writes_1,
  input  word_t        address_0, address_1,
  input  word_t        imm_0, imm_1,
  input  areg_t        rs_1_0, rs_2_0, rd_0,
  input  areg_t        rs_1_1, rs_2_1, rd_1,
  output logic         in_ack,
  output logic         stall,
  // Map table
  output areg_t        map_rs_1_0, map_rs_2_0, map_rd_0,
  output areg_t        map_rs_1_1, map_rs_2_1, map_rd_1,
  input  preg_t        map_ps_1_0, map_ps_2_0, map_old_pd_0,
  input  preg_t        map_ps_1_1, map_ps_2_1, map_old_pd_1,
  output logic         map_we_0, map_we_1,
  output preg_t        map_pd_0, map_pd_1,
  // Free list
  input  preg_t        head_0, head_1,
  output logic [1:0]   pop_count,
  // Dispatch side
  input  logic         dispatch_stall,
  input  logic         branch_resolved,
  output logic         out_valid,
  output instr_class_e out_class_0, out_class_1,
  output word_t        out_address_0, out_address_1,
  output word_t        out_imm_0, out_imm_1,
  output preg_t        out_ps_1_0, out_ps_2_0, out_ps_1_1, out_ps_2_1,
  output areg_t        out_rd_0, out_rd_1,
  output preg_t        out_pd_0, out_pd_1,
  output preg_t        out_old_pd_0, out_old_pd_1,
  output logic         out_tag_0, out_tag_1
);

  in_state_e in_state;
  logic      tag_active;
  logic      wr_0;
  logic      wr_1;
  logic      jump_0;
  logic      jump_1;
  logic      pair_present;
  logic      out_free;
  logic      accept;
  preg_t     pd_0;
  preg_t     pd_1;

  assign wr_0   = writes_0 && rd_0 != '0;  // x0 is never renamed
  assign wr_1   = writes_1 && rd_1 != '0;
  assign jump_0 = class_0 == CLASS_JUMP;
  assign jump_1 = class_1 == CLASS_JUMP;

  // Slot 1 takes the second head only when slot 0 used the first
  assign pd_0 = wr_0 ? head_0 : '0;
  assign pd_1 = !wr_1 ? '0 : (wr_0 ? head_1 : head_0);

  assign pair_present = in_req && in_state == IN_IDLE &&
                        class_0 != CLASS_NONE && class_1 != CLASS_NONE;
  assign stall    = pair_present && ((wr_0 && pd_0 == '0) || (wr_1 && pd_1 == '0));
  assign out_free = !out_valid || !dispatch_stall;
  assign accept   = pair_present && out_free && !stall;
  assign in_ack   = in_state != IN_IDLE;

  assign map_rs_1_0 = rs_1_0;
  assign map_rs_2_0 = rs_2_0;
  assign map_rd_0   = rd_0;
  assign map_rs_1_1 = rs_1_1;
  assign map_rs_2_1 = rs_2_1;
  assign map_rd_1   = rd_1;
  assign map_we_0   = accept && wr_0;
  assign map_we_1   = accept && wr_1;
  assign map_pd_0   = pd_0;
  assign map_pd_1   = pd_1;
  assign pop_count  = accept ? ({1'b0, wr_0} + {1'b0, wr_1}) : 2'd0;

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      in_state <= IN_IDLE;
    end else begin
      case (in_state)
        IN_IDLE:     in_state <= accept ? IN_ACK : IN_IDLE;
        IN_ACK:      in_state <= in_req ? IN_WAIT_LOW : IN_IDLE;
        IN_WAIT_LOW: in_state <= in_req ? IN_WAIT_LOW : IN_IDLE;
        default:     in_state <= IN_IDLE;
      endcase
    end
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      tag_active <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
      end else if (out_free) begin
        out_valid <= 1'b0;  // Drained by dispatch
      end
      // A new jump outranks a resolve in the same cycle
      if (accept && (jump_0 || jump_1)) begin
        tag_active <= 1'b1;
      end else if (branch_resolved) begin
        tag_active <= 1'b0;
      end
    end
  end

  always_ff @(posedge global_bus) begin
    if (accept) begin
      out_class_0   <= class_0;
      out_address_0 <= address_0;
      out_imm_0     <= imm_0;
      out_ps_1_0    <= map_ps_1_0;
      out_ps_2_0    <= map_ps_2_0;
      out_rd_0      <= rd_0;
      out_pd_0      <= pd_0;
      out_old_pd_0  <= wr_0 ? map_old_pd_0 : '0;
      out_tag_0     <= jump_0 ? 1'b0 : tag_active;

      out_class_1   <= class_1;
      out_address_1 <= address_1;
      out_imm_1     <= imm_1;
      out_ps_1_1    <= (wr_0 && rs_1_1 == rd_0) ? pd_0 : map_ps_1_1;  // In-pair bypass
      out_ps_2_1    <= (wr_0 && rs_2_1 == rd_0) ? pd_0 : map_ps_2_1;
      out_rd_1      <= rd_1;
      out_pd_1      <= pd_1;
      if (!wr_1) begin
        out_old_pd_1 <= '0;
      end else begin
        out_old_pd_1 <= (wr_0 && rd_1 == rd_0) ? pd_0 : map_old_pd_1;
      end
      if (jump_1) begin
        out_tag_1 <= 1'b0;
      end else begin
        out_tag_1 <= jump_0 ? 1'b1 : tag_active;  // Shadow of slot 0's jump
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rename_map.sv
/*
  Architectural to physical register map.
  Six combinational lookups serve the sources and old destinations of a pair,
  two write ports take the new mappings at the accepting edge.
*/
`timescale 1ns/1ns
`include "rename_params.svh"
`default_nettype none

module rename_map
  import rename_pkg::*;
(
  input  logic  global_bus,
  input  logic  rst_n,
  // Slot 0 lookups
  input  areg_t rs_1_0,
  input  areg_t rs_2_0,
  input  areg_t rd_0,
  // Slot 1 lookups
  input  areg_t rs_1_1,
  input  areg_t rs_2_1,
  input  areg_t rd_1,
  // New mappings
  input  logic  map_we_0,
  input  logic  map_we_1,
  input  preg_t pd_0,
  input  preg_t pd_1,
  // Lookup results
  output preg_t ps_1_0,
  output preg_t ps_2_0,
  output preg_t ps_1_1,
  output preg_t ps_2_1,
  output preg_t old_pd_0,
  output preg_t old_pd_1
);

  preg_t map_q [`ARCH_REGS];

  // x0 is hardwired and never renamed
  function automatic preg_t lookup(input areg_t a, input preg_t entry);
    return (a == '0) ? '0 : entry;
  endfunction

  always_comb begin
    ps_1_0   = lookup(rs_1_0, map_q[rs_1_0]);
    ps_2_0   = lookup(rs_2_0, map_q[rs_2_0]);
    ps_1_1   = lookup(rs_1_1, map_q[rs_1_1]);
    ps_2_1   = lookup(rs_2_1, map_q[rs_2_1]);
    old_pd_0 = lookup(rd_0, map_q[rd_0]);
    old_pd_1 = lookup(rd_1, map_q[rd_1]);
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);  // Identity map
      end
    end else begin
      if (map_we_0 && rd_0 != '0) begin
        map_q[rd_0] <= pd_0;
      end
      // Slot 1 is younger, so it overrides a same-rd write from slot 0
      if (map_we_1 && rd_1 != '0) begin
        map_q[rd_1] <= pd_1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/free_list.sv
/*
  Circular queue of free physical registers.
  The two oldest entries are offered as head_0 and head_1, the resolver pops
  0, 1 or 2 of them per pair, and retirement pushes released registers back.
*/
`timescale 1ns/1ns
`include "rename_params.svh"
`default_nettype none

module free_list
  import rename_pkg::*;
(
  input  logic              global_bus,
  input  logic              rst_n,
  input  logic [1:0]        pop_count,
  input  logic              release_valid,
  input  preg_t             release_preg,
  output preg_t             head_0,
  output preg_t             head_1,
  output logic [`PREG_W-1:0] free_count
);

  localparam int PTR_W = $clog2(`FREE_DEPTH);
  localparam int FIRST_FREE = `PHYS_REGS - `FREE_DEPTH;  // p32 after reset
  localparam logic [`PREG_W-1:0] DEPTH_CNT = `FREE_DEPTH;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [`PREG_W-1:0] count_t;

  preg_t queue [`FREE_DEPTH];
  ptr_t  rd_ptr;
  ptr_t  wr_ptr;
  ptr_t  rd_ptr_next;
  logic  push;

  assign rd_ptr_next = rd_ptr + ptr_t'(1);

  // p0 never enters the queue, a full queue only takes a push if it pops
  assign push = release_valid && release_preg != '0 &&
                (free_count != DEPTH_CNT || pop_count != 2'd0);

  // Missing entries read as 0, which the resolver treats as "no register"
  always_comb begin
    head_0 = '0;
    head_1 = '0;
    if (free_count != '0) begin
      head_0 = queue[rd_ptr];
    end
    if (free_count > count_t'(1)) begin
      head_1 = queue[rd_ptr_next];
    end
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      rd_ptr     <= '0;
      wr_ptr     <= '0;
      free_count <= DEPTH_CNT;
      for (int i = 0; i < `FREE_DEPTH; i++) begin
        queue[i] <= preg_t'(FIRST_FREE + i);  // Upper half of the file is free
      end
    end else begin
      rd_ptr <= rd_ptr + ptr_t'(pop_count);
      if (push) begin
        queue[wr_ptr] <= release_preg;
        wr_ptr        <= wr_ptr + ptr_t'(1);
      end
      free_count <= free_count + count_t'(push) - count_t'(pop_count);
    end
  end

endmodule

`default_nettype wire

// File: verilog/rename_pkg.sv
/*
  Types for the rename stage: register indices, payload word,
  instruction class and the input handshake states.
  Modules take them with a wildcard import in the module header.
*/
`include "rename_params.svh"
`default_nettype none

package rename_pkg;

  typedef logic [`AREG_W-1:0] areg_t;  // Architectural register index
  typedef logic [`PREG_W-1:0] preg_t;  // Physical register index, 0 means none
  typedef logic [`XLEN-1:0] word_t;    // Address or immediate

  // Decoded instruction class, one per slot
  typedef enum logic [1:0] {
    CLASS_NONE = 2'd0,  // Empty slot, the pair is not taken
    CLASS_ALU  = 2'd1,
    CLASS_MEM  = 2'd2,
    CLASS_JUMP = 2'd3   // Opens a speculation window
  } instr_class_e;

  // Four-phase input handshake
  typedef enum logic [1:0] {
    IN_IDLE     = 2'd0,
    IN_ACK      = 2'd1,  // First cycle with ack high
    IN_WAIT_LOW = 2'd2   // Ack held until req drops
  } in_state_e;

endpackage

`default_nettype wire

// File: verilog/rename_params.svh
/*
  Register counts and index widths for the rename stage.
  Included by the package and by every block that sizes storage from them.
*/
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural side, x0 to x31
`define ARCH_REGS 32
`define AREG_W 5

// Physical side, p0 is reserved as "no rename"
`define PHYS_REGS 64
`define PREG_W 6

`define XLEN 32        // Address and immediate width
`define FREE_DEPTH 32  // Free list capacity

`endif
